// File: all.f
+incdir+include
rtl/tryx_pkg.sv
rtl/tryx_ctrl.sv
rtl/ext_req_arbiter.sv
rtl/ext_req_fifo.sv
rtl/ext_bus_master.sv
rtl/tryx_subsys.sv
bench/ext_slave_model.sv
bench/tb_tryx_subsys.sv

// File: bench/ext_slave_model.sv
`timescale 1ns/1ps

module ext_slave_model #(
  parameter int unsigned SEED = 32'h0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 long_delay_i,
  input  logic                 ext_req_valid_i,
  input  tryx_pkg::ext_entry_t ext_req_i,
  output tryx_pkg::ext_rsp_t   ext_rsp_o
);

  import tryx_pkg::*;

  // Word memory indexed by address bits [5:2]
  logic [31:0] mem [16];

  initial begin
    ext_entry_t  acc;
    int unsigned delay;
    logic [3:0]  idx;
    void'($urandom(SEED));
    // Fill word carries its own index
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'hcafe_0000 | (i << 4) | i;
    end
    ext_rsp_o = '0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && ext_req_valid_i) begin
        acc = ext_req_i;
        idx = acc.add[5:2];
        // Long mode keeps the master busy so the FIFO backs up
        if (long_delay_i) begin
          delay = 24 + $urandom_range(7, 0);
        end else begin
          delay = $urandom_range(3, 0);
        end
        repeat (delay) @(posedge clk_i);
        #1;
        ext_rsp_o.valid  = 1'b1;
        // Error rule, bit 12 decode error and bit 13 slave error
        ext_rsp_o.decerr = acc.add[12];
        ext_rsp_o.slverr = acc.add[13];
        ext_rsp_o.rdata  = acc.wen ? mem[idx] : 32'h0;
        if (!acc.wen && !acc.add[12] && !acc.add[13]) begin
          mem[idx] = acc.wdata;
        end
        @(posedge clk_i);
        #1;
        ext_rsp_o = '0;
      end
    end
  end

endmodule

// File: bench/tb_tryx_subsys.sv
`timescale 1ns/1ps

`include "tryx_regs.svh"

module tb_tryx_subsys;

  import tryx_pkg::*;

  localparam int unsigned NB_CORES   = 2;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned TIMEOUT    = 500;
  localparam int unsigned NROWS      = 19;
  localparam logic [31:0] A_EXT      = `TRYX_CTRL_ADDREXT_ADDR;
  localparam logic [31:0] A_USR      = `TRYX_CTRL_USER_ADDR;

  typedef enum logic [1:0] {
    REG_WR,
    REG_RD,
    PT_RD,
    PT_WR
  } op_e;

  // One stimulus step with its expected external fields and read data
  typedef struct packed {
    logic [3:0]        core;
    op_e               op;
    logic [31:0]       addr;
    logic [31:0]       data;
    logic              unal;
    logic [USER_W-1:0] exp_user;
    logic [31:0]       exp_addrext;
    logic [31:0]       exp_rdata;
  } row_t;

  // Response pulse seen on one core port
  typedef struct packed {
    logic [3:0]  core;
    logic [31:0] rdata;
  } rsp_rec_t;

  logic                       clk;
  logic                       rst_n;
  logic                       slow;
  periph_req_t [NB_CORES-1:0] core_req;
  periph_rsp_t [NB_CORES-1:0] core_rsp;
  logic        [NB_CORES-1:0] unaligned;
  logic                       ext_req_valid;
  ext_entry_t                 ext_req;
  ext_rsp_t                   ext_rsp;

  ext_entry_t ext_log [$];
  rsp_rec_t   rsp_log [$];

  // Columns: core, op, address, data, unaligned, user, addrext, rdata
  row_t rows [NROWS] = '{
    // Fields of core 0, then a read stamped with them
    '{4'd0, REG_WR, A_EXT, 32'h0000_00a5, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd0, REG_WR, A_USR, 32'hac00_0000, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd0, REG_RD, A_USR, 32'h0, 1'b0, 6'h00, 32'h0, 32'hac00_0000},
    '{4'd0, PT_RD, 32'h2000_0010, 32'h0, 1'b0, 6'h2b, 32'h0000_00a5, 32'hcafe_0044},
    // Fields cleared after the first access
    '{4'd0, PT_WR, 32'h2000_0020, 32'h1234_5678, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd0, PT_RD, 32'h2000_0020, 32'h0, 1'b0, 6'h00, 32'h0, 32'h1234_5678},
    // Aligned decode error lands in [1:0]
    '{4'd0, REG_WR, A_USR, 32'h5400_0000, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd0, PT_RD, 32'h2000_1008, 32'h0, 1'b0, 6'h15, 32'h0, 32'hcafe_0022},
    '{4'd0, REG_RD, A_EXT, 32'h0, 1'b0, 6'h00, 32'h0, 32'h0000_0002},
    '{4'd0, REG_RD, A_USR, 32'h0, 1'b0, 6'h00, 32'h0, 32'h0000_0000},
    // Unaligned slave error lands in [3:2], user kept
    '{4'd0, REG_WR, A_USR, 32'h5400_0000, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd0, PT_RD, 32'h2000_2004, 32'h0, 1'b1, 6'h15, 32'h0, 32'hcafe_0011},
    '{4'd0, REG_RD, A_USR, 32'h0, 1'b0, 6'h00, 32'h0, 32'h5400_0004},
    '{4'd0, REG_RD, A_USR, 32'h0, 1'b0, 6'h00, 32'h0, 32'h5400_0000},
    '{4'd0, PT_RD, 32'h2000_0010, 32'h0, 1'b0, 6'h15, 32'h0, 32'hcafe_0044},
    // Separate fields for both cores
    '{4'd1, REG_WR, A_EXT, 32'h0000_0b01, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd1, REG_WR, A_USR, 32'h0400_0000, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd0, REG_WR, A_EXT, 32'h0000_0a00, 1'b0, 6'h00, 32'h0, 32'h0},
    '{4'd0, REG_WR, A_USR, 32'hfc00_0000, 1'b0, 6'h00, 32'h0, 32'h0}
  };

  tryx_subsys #(
    .NB_CORES   (NB_CORES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_tryx_subsys (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .core_req_i      (core_req),
    .core_rsp_o      (core_rsp),
    .unaligned_i     (unaligned),
    .ext_req_valid_o (ext_req_valid),
    .ext_req_o       (ext_req),
    .ext_rsp_i       (ext_rsp)
  );

  ext_slave_model #(
    .SEED (32'hebfc_dbba)
  ) u_ext_slave_model (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .long_delay_i    (slow),
    .ext_req_valid_i (ext_req_valid),
    .ext_req_i       (ext_req),
    .ext_rsp_o       (ext_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Record every external request and every core response
  always @(posedge clk) begin
    if (rst_n) begin
      if (ext_req_valid) begin
        ext_log.push_back(ext_req);
      end
      for (int c = 0; c < NB_CORES; c++) begin
        if (core_rsp[c].r_valid) begin
          // No access in this system reports an error opcode to the core
          compare("core_rsp.r_opc", core_rsp[c].r_opc, 1'b0);
          rsp_log.push_back('{core: 4'(c), rdata: core_rsp[c].r_rdata});
        end
      end
    end
  end

  task automatic stop_failed();
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [63:0] act,
                         input logic [63:0] expected);
    if (act !== expected) begin
      $display("Mismatch at %0t ns: %s actual %0h expected %0h", $time, name, act,
               expected);
      stop_failed();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    stop_failed();
  endtask

  // Same fill rule as the slave memory
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return 32'hcafe_0000 | (idx << 4) | idx;
  endfunction

  // Present a request and hold it until gnt, returns the cycles waited
  task automatic issue(input int c, input op_e op, input logic [31:0] addr,
                       input logic [31:0] data, input logic unal, output int waited);
    logic got;
    waited = 0;
    got    = 1'b0;
    core_req[c] = '{req: 1'b1, add: addr, wen: (op == REG_RD || op == PT_RD),
                    be: 4'hf, wdata: data};
    unaligned[c] = unal;
    while (!got) begin
      @(posedge clk);
      waited++;
      got = core_rsp[c].gnt;
      if (!got && waited >= TIMEOUT) begin
        report_timeout($sformatf("gnt on core %0d", c));
      end
    end
    #1;
    core_req[c].req = 1'b0;
    unaligned[c]    = 1'b0;
  endtask

  // Take the oldest recorded response of one core
  task automatic await_rsp(input int c, output logic [31:0] rdata);
    int  cycles;
    logic found;
    cycles = 0;
    found  = 1'b0;
    rdata  = '0;
    while (!found) begin
      for (int i = 0; i < rsp_log.size(); i++) begin
        if (!found && rsp_log[i].core == c) begin
          found = 1'b1;
          rdata = rsp_log[i].rdata;
          rsp_log.delete(i);
        end
      end
      if (!found) begin
        if (cycles >= TIMEOUT) begin
          report_timeout($sformatf("r_valid on core %0d", c));
        end
        @(posedge clk);
        #1;
        cycles++;
      end
    end
  endtask

  // Oldest external request against the expected stamped entry
  task automatic check_entry(input int c, input logic [31:0] addr, input logic rd,
                             input logic [31:0] wdata, input logic [USER_W-1:0] user,
                             input logic [31:0] addrext);
    ext_entry_t e;
    if (ext_log.size() == 0) begin
      $display("No external request seen for core %0d at %0t ns", c, $time);
      stop_failed();
    end
    e = ext_log.pop_front();
    compare("ext_req_o.core_id", e.core_id, c);
    compare("ext_req_o.add", e.add, addr);
    compare("ext_req_o.wen", e.wen, rd);
    compare("ext_req_o.be", e.be, 4'hf);
    if (!rd) begin
      compare("ext_req_o.wdata", e.wdata, wdata);
    end
    compare("ext_req_o.tryx.user", e.tryx.user, user);
    compare("ext_req_o.tryx.addrext", e.tryx.addrext, addrext);
  endtask

  task automatic apply_row(input row_t r);
    int          waited;
    logic [31:0] rdata;
    issue(r.core, r.op, r.addr, r.data, r.unal, waited);
    if (r.op == REG_WR || r.op == REG_RD) begin
      // Register answer one cycle after gnt, nothing external
      @(posedge clk);
      compare("core_rsp.r_valid", core_rsp[r.core].r_valid, 1'b1);
      #1;
      await_rsp(r.core, rdata);
      if (r.op == REG_RD) begin
        compare("core_rsp.r_rdata", rdata, r.exp_rdata);
      end
      // A leaked access would reach the external port within three cycles
      repeat (3) @(posedge clk);
      #1;
      compare("ext_req_valid_o count", ext_log.size(), 0);
    end else begin
      await_rsp(r.core, rdata);
      if (r.op == PT_RD) begin
        compare("core_rsp.r_rdata", rdata, r.exp_rdata);
      end
      check_entry(r.core, r.addr, r.op == PT_RD, r.data, r.exp_user, r.exp_addrext);
    end
  endtask

  // Both cores at once, core 1 wins since core 0 was granted last
  task automatic interleave_two();
    int          w0, w1;
    logic [31:0] rd0, rd1;
    fork
      begin
        issue(0, PT_RD, 32'h2000_0030, 32'h0, 1'b0, w0);
        await_rsp(0, rd0);
      end
      begin
        issue(1, PT_RD, 32'h2000_0034, 32'h0, 1'b0, w1);
        await_rsp(1, rd1);
      end
    join
    compare("core 0 r_rdata", rd0, fill_word(12));
    compare("core 1 r_rdata", rd1, fill_word(13));
    check_entry(1, 32'h2000_0034, 1'b1, 32'h0, 6'h01, 32'h0000_0b01);
    check_entry(0, 32'h2000_0030, 1'b1, 32'h0, 6'h3f, 32'h0000_0a00);
  endtask

  // Slow slave, enough requests to fill the FIFO and stall one grant
  task automatic burst_fill();
    int          waited;
    logic [31:0] rdata;
    slow = 1'b1;
    for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
      issue(0, PT_RD, 32'h2000_0000 + 4 * k, 32'h0, 1'b0, waited);
      if (k == FIFO_DEPTH + 1) begin
        compare("gnt withheld while FIFO full", waited > 2, 1'b1);
      end
    end
    for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
      await_rsp(0, rdata);
      compare("burst r_rdata", rdata, fill_word(k));
    end
    // External order follows grant order
    for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
      check_entry(0, 32'h2000_0000 + 4 * k, 1'b1, 32'h0, 6'h00, 32'h0);
    end
    slow = 1'b0;
  endtask

  initial begin
    rst_n     = 1'b0;
    slow      = 1'b0;
    core_req  = '0;
    unaligned = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int n = 0; n < NROWS; n++) begin
      apply_row(rows[n]);
    end
    interleave_two();
    burst_fill();
    // Nothing left over, so no core saw a foreign response
    compare("unclaimed core responses", rsp_log.size(), 0);
    compare("unchecked ext_req_o entries", ext_log.size(), 0);
    $display("Test passed");
    $finish;
  end

endmodule

// File: include/tryx_regs.svh
`ifndef TRYX_REGS_SVH
`define TRYX_REGS_SVH

// Per-core control registers, decoded in the core data port
// Address extension word for the next external access
`define TRYX_CTRL_ADDREXT_ADDR 32'h1020_0BF8

// External user field, taken from the top bits of the written word
`define TRYX_CTRL_USER_ADDR 32'h1020_0BFC

`endif

// File: rtl/ext_bus_master.sv
`timescale 1ns/1ps

module ext_bus_master #(
  parameter int unsigned NB_CORES = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  tryx_pkg::ext_entry_t                  head_i,
  input  logic                                  not_empty_i,
  output logic                                  pop_o,
  output logic                                  ext_req_valid_o,
  output tryx_pkg::ext_entry_t                  ext_req_o,
  input  tryx_pkg::ext_rsp_t                    ext_rsp_i,
  output tryx_pkg::periph_rsp_t [NB_CORES-1:0]  fwd_rsp_o,
  output logic                  [NB_CORES-1:0]  axi_xresp_valid_o,
  output logic                  [NB_CORES-1:0]  axi_xresp_decerr_o,
  output logic                  [NB_CORES-1:0]  axi_xresp_slverr_o
);

  import tryx_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e      state_d, state_q;
  ext_entry_t  req_q;
  logic        valid_q;
  logic        rsp_valid_q;
  logic        decerr_q, slverr_q;
  logic [31:0] rdata_q;

  // One access at a time, no pop while a response is pending
  always_comb begin
    state_d = state_q;
    pop_o   = 1'b0;
    case (state_q)
      IDLE: begin
        if (not_empty_i) begin
          pop_o   = 1'b1;
          state_d = BUSY;
        end
      end
      BUSY: begin
        if (ext_rsp_i.valid) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      valid_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      valid_q     <= pop_o;
      rsp_valid_q <= (state_q == BUSY) && ext_rsp_i.valid;
    end
  end

  // Issued entry stays put until the next pop, so it still names the core
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      req_q <= head_i;
    end
    if (ext_rsp_i.valid) begin
      rdata_q  <= ext_rsp_i.rdata;
      decerr_q <= ext_rsp_i.decerr;
      slverr_q <= ext_rsp_i.slverr;
    end
  end

  assign ext_req_valid_o = valid_q;
  assign ext_req_o       = req_q;

  // Route the response pulse back to the issuing core
  for (genvar i = 0; i < NB_CORES; i++) begin : gen_rsp
    logic hit;

    assign hit = rsp_valid_q && (req_q.core_id == CORE_ID_W'(i));

    assign fwd_rsp_o[i].gnt     = 1'b0;
    assign fwd_rsp_o[i].r_valid = hit;
    assign fwd_rsp_o[i].r_opc   = 1'b0;
    assign fwd_rsp_o[i].r_rdata = rdata_q;

    assign axi_xresp_valid_o[i]  = hit;
    assign axi_xresp_decerr_o[i] = hit && decerr_q;
    assign axi_xresp_slverr_o[i] = hit && slverr_q;
  end

  // The external slave answers only an issued access
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ext_rsp_i.valid |-> (state_q == BUSY));

endmodule

// File: rtl/ext_req_arbiter.sv
`timescale 1ns/1ps

module ext_req_arbiter #(
  parameter int unsigned NB_CORES = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  tryx_pkg::periph_req_t [NB_CORES-1:0]  fwd_req_i,
  input  tryx_pkg::tryx_req_t   [NB_CORES-1:0]  tryx_req_i,
  output logic                  [NB_CORES-1:0]  fwd_gnt_o,
  input  logic                                  fifo_full_i,
  output logic                                  push_o,
  output tryx_pkg::ext_entry_t                  push_entry_o
);

  import tryx_pkg::*;

  localparam int unsigned IDX_W = (NB_CORES > 1) ? $clog2(NB_CORES) : 1;

  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] sel;
  logic             found;
  ext_entry_t       entry;

  // Search starts right after the last granted core
  always_comb begin
    int unsigned idx;
    sel   = last_q;
    found = 1'b0;
    for (int unsigned k = 1; k <= NB_CORES; k++) begin
      idx = (int'(last_q) + k) % NB_CORES;
      if (!found && fwd_req_i[idx].req) begin
        found = 1'b1;
        sel   = IDX_W'(idx);
      end
    end
  end

  // Grant and push are one event, held off while the FIFO is full
  assign push_o = found && !fifo_full_i;

  always_comb begin
    fwd_gnt_o = '0;
    if (push_o) begin
      fwd_gnt_o[sel] = 1'b1;
    end
  end

  // Stamp the winner's request with its tag and extension fields
  always_comb begin
    entry.core_id = CORE_ID_W'(sel);
    entry.wen     = fwd_req_i[sel].wen;
    entry.add     = fwd_req_i[sel].add;
    entry.be      = fwd_req_i[sel].be;
    entry.wdata   = fwd_req_i[sel].wdata;
    entry.tryx    = tryx_req_i[sel];
  end

  assign push_entry_o = entry;

  // Reset so that core 0 has first priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= IDX_W'(NB_CORES - 1);
    end else if (push_o) begin
      last_q <= sel;
    end
  end

  // At most one core wins per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(fwd_gnt_o));

endmodule

// File: rtl/ext_req_fifo.sv
`timescale 1ns/1ps

module ext_req_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  tryx_pkg::ext_entry_t  push_entry_i,
  output logic                  full_o,
  input  logic                  pop_i,
  output tryx_pkg::ext_entry_t  head_o,
  output logic                  not_empty_o
);

  import tryx_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  ext_entry_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_o      = mem_q[rd_ptr_q];
  assign full_o      = (cnt_q == CNT_W'(DEPTH));
  assign not_empty_o = (cnt_q != '0);

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  // Pointers and fill level, push and pop may coincide
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && pop_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> not_empty_o);

endmodule

// File: rtl/tryx_ctrl.sv
`timescale 1ns/1ps

`include "tryx_regs.svh"

module tryx_ctrl #(
  parameter int unsigned NB_CORES = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  tryx_pkg::periph_req_t [NB_CORES-1:0]  core_req_i,
  output tryx_pkg::periph_rsp_t [NB_CORES-1:0]  core_rsp_o,
  output tryx_pkg::periph_req_t [NB_CORES-1:0]  fwd_req_o,
  input  tryx_pkg::periph_rsp_t [NB_CORES-1:0]  fwd_rsp_i,
  output tryx_pkg::tryx_req_t   [NB_CORES-1:0]  tryx_req_o,
  input  logic                  [NB_CORES-1:0]  axi_xresp_valid_i,
  input  logic                  [NB_CORES-1:0]  axi_xresp_decerr_i,
  input  logic                  [NB_CORES-1:0]  axi_xresp_slverr_i,
  input  logic                  [NB_CORES-1:0]  unaligned_i
);

  import tryx_pkg::*;

  // Forwarded accesses a core can have in flight, FIFO plus master
  localparam int unsigned CNT_W = 4;

  for (genvar i = 0; i < NB_CORES; i++) begin : gen_core
    periph_req_t      req;
    periph_req_t      fwd_req;
    periph_rsp_t      rsp;
    periph_rsp_t      fwd_rsp;
    tryx_req_t        tryx_d, tryx_q;
    logic             is_reg;
    logic             wr_en, rd_en;
    logic             reg_rsp_q, rd_q;
    logic             fwd_gnt, fwd_done;
    logic             unaligned_d, unaligned_q;
    logic [CNT_W-1:0] pend_d, pend_q;
    logic [1:0]       err;
    logic [3:0]       err_d, err_q;

    assign req     = core_req_i[i];
    assign fwd_rsp = fwd_rsp_i[i];

    assign fwd_req_o[i]  = fwd_req;
    assign core_rsp_o[i] = rsp;
    assign tryx_req_o[i] = tryx_q;

    // Control register decode on the full address
    assign is_reg = (req.add == `TRYX_CTRL_ADDREXT_ADDR) ||
                    (req.add == `TRYX_CTRL_USER_ADDR);

    // Steer the request, either local register access or the external path
    always_comb begin
      fwd_req     = req;
      fwd_req.req = req.req && !is_reg;
      wr_en       = req.req && is_reg && !req.wen;
      rd_en       = req.req && is_reg && req.wen;
    end

    assign fwd_gnt  = fwd_req.req && fwd_rsp.gnt;
    // Response of a forwarded access this core is still waiting for
    assign fwd_done = fwd_rsp.r_valid && (pend_q != '0);

    // Response mux, register answers take the cycle after their grant
    always_comb begin
      rsp.gnt = is_reg ? req.req : fwd_gnt;
      if (reg_rsp_q) begin
        rsp.r_valid = 1'b1;
        rsp.r_opc   = 1'b0;
        rsp.r_rdata = {tryx_q.user, {(32 - USER_W - 4){1'b0}}, err_q};
      end else begin
        rsp.r_valid = fwd_rsp.r_valid;
        rsp.r_opc   = fwd_rsp.r_opc;
        rsp.r_rdata = fwd_rsp.r_rdata;
      end
    end

    // Count forwarded accesses between grant and response
    always_comb begin
      pend_d = pend_q;
      if (fwd_gnt && !fwd_done) begin
        pend_d = pend_q + 1'b1;
      end else if (!fwd_gnt && fwd_done) begin
        pend_d = pend_q - 1'b1;
      end
    end

    // Unaligned tracker, a new unaligned grant wins over a response
    always_comb begin
      unaligned_d = unaligned_q;
      if (fwd_done) begin
        unaligned_d = 1'b0;
      end
      if (fwd_gnt && unaligned_i[i]) begin
        unaligned_d = 1'b1;
      end
    end

    // Error latch, upper slot for unaligned and lower slot otherwise
    assign err = {axi_xresp_decerr_i[i], axi_xresp_slverr_i[i]};
    always_comb begin
      err_d = err_q;
      if (axi_xresp_valid_i[i]) begin
        if (unaligned_q) begin
          err_d[3:2] = err;
        end else begin
          err_d[1:0] = err;
        end
      end else if (rd_q) begin
        // Read of a control register consumes the error field
        err_d = '0;
      end
    end

    // Extension fields, a register write beats the self-clear
    always_comb begin
      tryx_d = tryx_q;
      if (wr_en) begin
        if (req.add == `TRYX_CTRL_USER_ADDR) begin
          tryx_d.user = req.wdata[31 -: USER_W];
        end else begin
          tryx_d.addrext = req.wdata;
        end
      end else if (fwd_done && !unaligned_q) begin
        tryx_d = '0;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        reg_rsp_q   <= 1'b0;
        rd_q        <= 1'b0;
        pend_q      <= '0;
        unaligned_q <= 1'b0;
        err_q       <= '0;
        tryx_q      <= '0;
      end else begin
        reg_rsp_q   <= wr_en || rd_en;
        rd_q        <= rd_en;
        pend_q      <= pend_d;
        unaligned_q <= unaligned_d;
        err_q       <= err_d;
        tryx_q      <= tryx_d;
      end
    end

    // Every response toward the core answers an earlier grant
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp.r_valid |-> (reg_rsp_q || (pend_q != '0)));

    // A register answer never collides with an external response
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      reg_rsp_q |-> !fwd_rsp.r_valid);
  end

endmodule

// File: rtl/tryx_pkg.sv
package tryx_pkg;

  // Width of the external user field
  localparam int unsigned USER_W = 6;

  // Core tag carried with every external access, up to 16 cores
  localparam int unsigned CORE_ID_W = 4;

  // Core data port request, wen high means read
  typedef struct packed {
    logic        req;
    logic [31:0] add;
    logic        wen;
    logic [3:0]  be;
    logic [31:0] wdata;
  } periph_req_t;

  // Core data port response
  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic        r_opc;
    logic [31:0] r_rdata;
  } periph_rsp_t;

  // Extension fields stamped onto external accesses
  typedef struct packed {
    logic [31:0]       addrext;
    logic [USER_W-1:0] user;
  } tryx_req_t;

  // One queued external access
  typedef struct packed {
    logic [CORE_ID_W-1:0] core_id;
    logic                 wen;
    logic [31:0]          add;
    logic [3:0]           be;
    logic [31:0]          wdata;
    tryx_req_t            tryx;
  } ext_entry_t;

  // External bus response, valid is a single-cycle pulse
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic        decerr;
    logic        slverr;
  } ext_rsp_t;

endpackage

// File: rtl/tryx_subsys.sv
`timescale 1ns/1ps

module tryx_subsys #(
  parameter int unsigned NB_CORES   = 2,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  tryx_pkg::periph_req_t [NB_CORES-1:0]  core_req_i,
  output tryx_pkg::periph_rsp_t [NB_CORES-1:0]  core_rsp_o,
  input  logic                  [NB_CORES-1:0]  unaligned_i,
  output logic                                  ext_req_valid_o,
  output tryx_pkg::ext_entry_t                  ext_req_o,
  input  tryx_pkg::ext_rsp_t                    ext_rsp_i
);

  import tryx_pkg::*;

  periph_req_t [NB_CORES-1:0] fwd_req;
  periph_rsp_t [NB_CORES-1:0] fwd_rsp;
  periph_rsp_t [NB_CORES-1:0] mst_rsp;
  tryx_req_t   [NB_CORES-1:0] tryx_req;
  logic        [NB_CORES-1:0] arb_gnt;
  logic        [NB_CORES-1:0] xresp_valid, xresp_decerr, xresp_slverr;
  logic                       fifo_full, push, pop, not_empty;
  ext_entry_t                 push_entry, head;

  // Grant from the arbiter, response data from the bus master
  for (genvar i = 0; i < NB_CORES; i++) begin : gen_fwd_rsp
    assign fwd_rsp[i] = '{gnt:     arb_gnt[i],
                          r_valid: mst_rsp[i].r_valid,
                          r_opc:   mst_rsp[i].r_opc,
                          r_rdata: mst_rsp[i].r_rdata};
  end

  tryx_ctrl #(
    .NB_CORES (NB_CORES)
  ) u_tryx_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .core_req_i         (core_req_i),
    .core_rsp_o         (core_rsp_o),
    .fwd_req_o          (fwd_req),
    .fwd_rsp_i          (fwd_rsp),
    .tryx_req_o         (tryx_req),
    .axi_xresp_valid_i  (xresp_valid),
    .axi_xresp_decerr_i (xresp_decerr),
    .axi_xresp_slverr_i (xresp_slverr),
    .unaligned_i        (unaligned_i)
  );

  ext_req_arbiter #(
    .NB_CORES (NB_CORES)
  ) u_ext_req_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fwd_req_i    (fwd_req),
    .tryx_req_i   (tryx_req),
    .fwd_gnt_o    (arb_gnt),
    .fifo_full_i  (fifo_full),
    .push_o       (push),
    .push_entry_o (push_entry)
  );

  ext_req_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_ext_req_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_entry_i (push_entry),
    .full_o       (fifo_full),
    .pop_i        (pop),
    .head_o       (head),
    .not_empty_o  (not_empty)
  );

  ext_bus_master #(
    .NB_CORES (NB_CORES)
  ) u_ext_bus_master (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .head_i             (head),
    .not_empty_i        (not_empty),
    .pop_o              (pop),
    .ext_req_valid_o    (ext_req_valid_o),
    .ext_req_o          (ext_req_o),
    .ext_rsp_i          (ext_rsp_i),
    .fwd_rsp_o          (mst_rsp),
    .axi_xresp_valid_o  (xresp_valid),
    .axi_xresp_decerr_o (xresp_decerr),
    .axi_xresp_slverr_o (xresp_slverr)
  );

endmodule
